// File: include/io_regs_cfg.svh
`ifndef IO_REGS_CFG_SVH
`define IO_REGS_CFG_SVH

// Register offsets in the I/O page
`define IO_OFS_SB   8'h01
`define IO_OFS_SC   8'h02
`define IO_OFS_DIV  8'h04
`define IO_OFS_TIMA 8'h05
`define IO_OFS_TMA  8'h06
`define IO_OFS_TAC  8'h07
`define IO_OFS_IF   8'h0F
`define IO_OFS_KEY1 8'h4D
`define IO_OFS_RP   8'h56
`define IO_OFS_IE   8'hFF

// Bits that always read back as one
`define IO_MASK_SB   8'h00
`define IO_MASK_SC   8'h7C
`define IO_MASK_KEY1 8'hFD
`define IO_MASK_RP   8'h3E
`define IO_MASK_TAC  8'hF8
`define IO_MASK_IF   8'hE0

`define IO_UNMAPPED_DATA 8'hFF
`define IO_RESET_BYTE    8'h00

// Divider and TIMA rate taps
`define IO_DIV_WIDTH 16
`define IO_TAP_SEL0  9
`define IO_TAP_SEL1  3
`define IO_TAP_SEL2  5
`define IO_TAP_SEL3  7
`define IO_IRQ_COUNT 5

`endif

// File: hdl/io_regs_pkg.sv
package io_regs_pkg;

   typedef logic [7:0] io_byte_t;
   typedef logic [7:0] io_ofs_t;

   // APB slave side
   typedef struct packed {
      logic     psel;
      logic     penable;
      logic     pwrite;
      io_ofs_t  paddr;
      io_byte_t pwdata;
   } apb_req_t;

   typedef struct packed {
      io_byte_t prdata;
      logic     pready;
      logic     pslverr;
   } apb_rsp_t;

   typedef enum logic [3:0] {
      SEL_SB, SEL_SC, SEL_DIV, SEL_TIMA, SEL_TMA, SEL_TAC,
      SEL_IF, SEL_KEY1, SEL_RP, SEL_IE, SEL_NONE
   } reg_sel_t;

   // TAC layout, low three bits live
   typedef struct packed {
      logic [4:0] unused;
      logic       enable;
      logic [1:0] rate;
   } tac_fields_t;

   typedef union packed {
      io_byte_t    raw;
      tac_fields_t tac;
   } io_byte_u;

   typedef struct packed {
      logic     valid;
      reg_sel_t sel;
      io_byte_u data;
   } reg_write_t;

   // Bit order matches the IF/IE registers
   typedef struct packed {
      logic joypad;
      logic serial;
      logic timer;
      logic lcdstat;
      logic vblank;
   } irq_vec_t;

endpackage

// File: hdl/io_bus_control.sv
`timescale 1ns/1ps
`include "io_regs_cfg.svh"

module io_bus_control (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  io_regs_pkg::apb_req_t   apb_req,
   output io_regs_pkg::apb_rsp_t   apb_rsp,
   output io_regs_pkg::reg_write_t wr,
   input  io_regs_pkg::io_byte_t   div_rd,
   input  io_regs_pkg::io_byte_t   tima_rd,
   input  io_regs_pkg::io_byte_t   tma_rd,
   input  io_regs_pkg::io_byte_t   tac_rd,
   input  io_regs_pkg::io_byte_t   if_rd,
   input  io_regs_pkg::io_byte_t   ie_rd,
   input  io_regs_pkg::io_byte_t   sb_rd,
   input  io_regs_pkg::io_byte_t   sc_rd,
   input  io_regs_pkg::io_byte_t   key1_rd,
   input  io_regs_pkg::io_byte_t   rp_rd
);
   import io_regs_pkg::*;

   reg_sel_t sel;
   logic     setup_q;
   logic     access;
   logic     mapped;
   io_byte_t rd_byte;

   // Remembers a setup cycle so the access phase is only accepted after one
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= apb_req.psel & ~apb_req.penable;
      end
   end

   assign access = apb_req.psel & apb_req.penable & setup_q;

   // ========================================
   // Address map
   // ========================================
   always_comb begin
      case (apb_req.paddr)
         `IO_OFS_SB:   sel = SEL_SB;
         `IO_OFS_SC:   sel = SEL_SC;
         `IO_OFS_DIV:  sel = SEL_DIV;
         `IO_OFS_TIMA: sel = SEL_TIMA;
         `IO_OFS_TMA:  sel = SEL_TMA;
         `IO_OFS_TAC:  sel = SEL_TAC;
         `IO_OFS_IF:   sel = SEL_IF;
         `IO_OFS_KEY1: sel = SEL_KEY1;
         `IO_OFS_RP:   sel = SEL_RP;
         `IO_OFS_IE:   sel = SEL_IE;
         default:      sel = SEL_NONE;
      endcase
   end

   assign mapped = (sel != SEL_NONE);

   // Read data mux, masks already applied by the owners
   always_comb begin
      case (sel)
         SEL_SB:   rd_byte = sb_rd;
         SEL_SC:   rd_byte = sc_rd;
         SEL_DIV:  rd_byte = div_rd;
         SEL_TIMA: rd_byte = tima_rd;
         SEL_TMA:  rd_byte = tma_rd;
         SEL_TAC:  rd_byte = tac_rd;
         SEL_IF:   rd_byte = if_rd;
         SEL_KEY1: rd_byte = key1_rd;
         SEL_RP:   rd_byte = rp_rd;
         SEL_IE:   rd_byte = ie_rd;
         default:  rd_byte = `IO_UNMAPPED_DATA;
      endcase
   end

   // ========================================
   // Outputs
   // ========================================
   always_comb begin
      wr.valid    = access & apb_req.pwrite & mapped;
      wr.sel      = sel;
      wr.data.raw = apb_req.pwdata;
   end

   // Zero wait states, no back-pressure
   always_comb begin
      apb_rsp.prdata  = rd_byte;
      apb_rsp.pready  = 1'b1;
      apb_rsp.pslverr = access & ~mapped;
   end

endmodule

// File: hdl/timer_unit.sv
`timescale 1ns/1ps
`include "io_regs_cfg.svh"

module timer_unit (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  io_regs_pkg::reg_write_t wr,
   output io_regs_pkg::io_byte_t   div_rd,
   output io_regs_pkg::io_byte_t   tima_rd,
   output io_regs_pkg::io_byte_t   tma_rd,
   output io_regs_pkg::io_byte_t   tac_rd,
   output logic                    timer_irq
);
   import io_regs_pkg::*;

   logic [`IO_DIV_WIDTH-1:0] div_cnt;
   io_byte_t                 tima_q;
   io_byte_t                 tma_q;
   tac_fields_t              tac_q;
   logic                     tap_now;
   logic                     tap_q;
   logic                     tick;
   logic                     wr_div, wr_tima, wr_tma, wr_tac;

   assign wr_div  = wr.valid && (wr.sel == SEL_DIV);
   assign wr_tima = wr.valid && (wr.sel == SEL_TIMA);
   assign wr_tma  = wr.valid && (wr.sel == SEL_TMA);
   assign wr_tac  = wr.valid && (wr.sel == SEL_TAC);

   // ========================================
   // Divider and rate tap
   // ========================================
   always_ff @(posedge clock_in) begin
      if (synch_reset || wr_div) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   always_comb begin
      case (tac_q.rate)
         2'd0:    tap_now = div_cnt[`IO_TAP_SEL0];
         2'd1:    tap_now = div_cnt[`IO_TAP_SEL1];
         2'd2:    tap_now = div_cnt[`IO_TAP_SEL2];
         default: tap_now = div_cnt[`IO_TAP_SEL3];
      endcase
   end

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         tap_q <= 1'b0;
      end else begin
         tap_q <= tap_now;
      end
   end

   // Step on a falling tap edge
   assign tick = tac_q.enable & tap_q & ~tap_now;

   // ========================================
   // TIMA with reload from TMA
   // ========================================
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         tima_q    <= `IO_RESET_BYTE;
         timer_irq <= 1'b0;
      end else begin
         timer_irq <= 1'b0;
         if (wr_tima) begin
            tima_q <= wr.data.raw;
         end else if (tick) begin
            if (tima_q == 8'hFF) begin
               tima_q    <= tma_q;
               timer_irq <= 1'b1;
            end else begin
               tima_q <= tima_q + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         tma_q <= `IO_RESET_BYTE;
         tac_q <= `IO_RESET_BYTE;
      end else begin
         if (wr_tma) tma_q <= wr.data.raw;
         if (wr_tac) begin
            tac_q.unused <= '0;
            tac_q.enable <= wr.data.tac.enable;
            tac_q.rate   <= wr.data.tac.rate;
         end
      end
   end

   assign div_rd  = div_cnt[`IO_DIV_WIDTH-1 -: 8];
   assign tima_rd = tima_q;
   assign tma_rd  = tma_q;
   assign tac_rd  = tac_q | `IO_MASK_TAC;

endmodule

// File: hdl/interrupt_unit.sv
`timescale 1ns/1ps
`include "io_regs_cfg.svh"

module interrupt_unit (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  io_regs_pkg::reg_write_t wr,
   input  io_regs_pkg::irq_vec_t   irq_src,
   input  logic                    timer_irq,
   output io_regs_pkg::io_byte_t   if_rd,
   output io_regs_pkg::io_byte_t   ie_rd,
   output io_regs_pkg::irq_vec_t   irq_lines
);
   import io_regs_pkg::*;

   irq_vec_t if_q;
   irq_vec_t ie_q;
   irq_vec_t src_vec;
   irq_vec_t if_next;

   // Timer request comes from the timer, not the pins
   always_comb begin
      src_vec       = irq_src;
      src_vec.timer = timer_irq;
   end

   // Write first, then sources set on top of it
   always_comb begin
      if_next = if_q;
      if (wr.valid && (wr.sel == SEL_IF)) begin
         if_next = wr.data.raw[`IO_IRQ_COUNT-1:0];
      end
      if_next = if_next | src_vec;
   end

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         if_q      <= '0;
         ie_q      <= '0;
         irq_lines <= '0;
      end else begin
         if_q      <= if_next;
         irq_lines <= if_q & ie_q;
         if (wr.valid && (wr.sel == SEL_IE)) begin
            ie_q <= wr.data.raw[`IO_IRQ_COUNT-1:0];
         end
      end
   end

   // Upper IF bits read one, upper IE bits read zero
   assign if_rd = {{(8-`IO_IRQ_COUNT){1'b0}}, if_q} | `IO_MASK_IF;
   assign ie_rd = {{(8-`IO_IRQ_COUNT){1'b0}}, ie_q};

endmodule

// File: hdl/misc_reg_bank.sv
`timescale 1ns/1ps
`include "io_regs_cfg.svh"

module misc_reg_bank (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  io_regs_pkg::reg_write_t wr,
   output io_regs_pkg::io_byte_t   sb_rd,
   output io_regs_pkg::io_byte_t   sc_rd,
   output io_regs_pkg::io_byte_t   key1_rd,
   output io_regs_pkg::io_byte_t   rp_rd
);
   import io_regs_pkg::*;

   io_byte_t sb_q;
   io_byte_t sc_q;
   io_byte_t key1_q;
   io_byte_t rp_q;

   // Serial data/control, speed switch and IR port
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         sb_q   <= `IO_RESET_BYTE;
         sc_q   <= `IO_RESET_BYTE;
         key1_q <= `IO_RESET_BYTE;
         rp_q   <= `IO_RESET_BYTE;
      end else if (wr.valid) begin
         case (wr.sel)
            SEL_SB:   sb_q   <= wr.data.raw;
            SEL_SC:   sc_q   <= wr.data.raw;
            SEL_KEY1: key1_q <= wr.data.raw;
            SEL_RP:   rp_q   <= wr.data.raw;
            default: begin
               sb_q <= sb_q;
            end
         endcase
      end
   end

   // ========================================
   // Read back with fixed ones
   // ========================================
   assign sb_rd   = sb_q   | `IO_MASK_SB;
   assign sc_rd   = sc_q   | `IO_MASK_SC;
   assign key1_rd = key1_q | `IO_MASK_KEY1;
   assign rp_rd   = rp_q   | `IO_MASK_RP;

endmodule

// File: hdl/io_regs_top.sv
`timescale 1ns/1ps

module io_regs_top (
   input  logic                  clock_in,
   input  logic                  synch_reset,
   input  io_regs_pkg::apb_req_t apb_req,
   output io_regs_pkg::apb_rsp_t apb_rsp,
   input  io_regs_pkg::irq_vec_t irq_src,
   output io_regs_pkg::irq_vec_t irq_lines
);
   import io_regs_pkg::*;

   reg_write_t wr;
   io_byte_t   div_rd, tima_rd, tma_rd, tac_rd;
   io_byte_t   if_rd, ie_rd;
   io_byte_t   sb_rd, sc_rd, key1_rd, rp_rd;
   logic       timer_irq;

   // ========================================
   // Bus side
   // ========================================
   io_bus_control io_bus_control_inst (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .wr          (wr),
      .div_rd      (div_rd),
      .tima_rd     (tima_rd),
      .tma_rd      (tma_rd),
      .tac_rd      (tac_rd),
      .if_rd       (if_rd),
      .ie_rd       (ie_rd),
      .sb_rd       (sb_rd),
      .sc_rd       (sc_rd),
      .key1_rd     (key1_rd),
      .rp_rd       (rp_rd)
   );

   // ========================================
   // Register owners
   // ========================================
   timer_unit timer_unit_inst (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .wr          (wr),
      .div_rd      (div_rd),
      .tima_rd     (tima_rd),
      .tma_rd      (tma_rd),
      .tac_rd      (tac_rd),
      .timer_irq   (timer_irq)
   );

   interrupt_unit interrupt_unit_inst (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .wr          (wr),
      .irq_src     (irq_src),
      .timer_irq   (timer_irq),
      .if_rd       (if_rd),
      .ie_rd       (ie_rd),
      .irq_lines   (irq_lines)
   );

   misc_reg_bank misc_reg_bank_inst (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .wr          (wr),
      .sb_rd       (sb_rd),
      .sc_rd       (sc_rd),
      .key1_rd     (key1_rd),
      .rp_rd       (rp_rd)
   );

endmodule

// File: verif/io_regs_tb.sv
`timescale 1ns/1ps

module io_regs_tb;
   import io_regs_pkg::*;

   localparam int    CLOCK_HALF     = 10;
   localparam int    READY_TIMEOUT  = 16;
   localparam int    DIV_POLL_LIMIT = 128;
   localparam string CASE_FILE      = "verif/io_regs_cases.txt";

   logic     clock_in;
   logic     synch_reset;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;
   irq_vec_t irq_src;
   irq_vec_t irq_lines;
   int       case_count;

   io_regs_top io_regs_top_inst (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .irq_src     (irq_src),
      .irq_lines   (irq_lines)
   );

   initial begin
      clock_in = 1'b0;
      forever begin
         #CLOCK_HALF clock_in = ~clock_in;
      end
   end

   // ========================================
   // Failure handling and compare tasks
   // ========================================
   task automatic abort_run(input string reason);
      begin
         $display("%s", reason);
         $display("ERRORS FOUND");
         $fatal(1, "Simulation stopped");
      end
   endtask

   task automatic check_byte(input string name, input io_byte_t exp, input io_byte_t act);
      if (act !== exp) begin
         abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   // Handshake and error flag only, read data goes through check_byte
   task automatic check_rsp(input string name, input apb_rsp_t exp, input apb_rsp_t act);
      if ((act.pready !== exp.pready) || (act.pslverr !== exp.pslverr)) begin
         abort_run($sformatf(
            "Mismatch in %s: expected pready=%b pslverr=%b, actual pready=%b pslverr=%b",
            name, exp.pready, exp.pslverr, act.pready, act.pslverr));
      end
   endtask

   task automatic check_irq(input string name, input irq_vec_t exp, input irq_vec_t act);
      if (act !== exp) begin
         abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // ========================================
   // APB driver and irq helpers
   // ========================================
   task automatic apb_transfer(input logic write, input io_ofs_t ofs, input io_byte_t data,
                               output apb_rsp_t rsp);
      apb_req_t req;
      int       waited;
      begin
         req.psel    = 1'b1;
         req.penable = 1'b0;
         req.pwrite  = write;
         req.paddr   = ofs;
         req.pwdata  = data;
         @(posedge clock_in);
         apb_req <= req;
         req.penable = 1'b1;
         @(posedge clock_in);
         apb_req <= req;
         // Access phase lasts until pready
         waited = 0;
         @(negedge clock_in);
         while (!apb_rsp.pready && (waited < READY_TIMEOUT)) begin
            @(negedge clock_in);
            waited = waited + 1;
         end
         if (!apb_rsp.pready) begin
            abort_run($sformatf("Timeout: pready wait expired at offset %h", ofs));
         end else begin
            rsp = apb_rsp;
            @(posedge clock_in);
            apb_req <= '0;
         end
      end
   endtask

   // Repeats a read until it returns the expected byte
   task automatic poll_read(input string name, input io_ofs_t ofs, input io_byte_t exp,
                            input int limit);
      apb_rsp_t rsp;
      int       polls;
      begin
         polls = 0;
         apb_transfer(1'b0, ofs, 8'h00, rsp);
         while ((rsp.prdata !== exp) && (polls < limit)) begin
            apb_transfer(1'b0, ofs, 8'h00, rsp);
            polls = polls + 1;
         end
         if (rsp.prdata !== exp) begin
            abort_run($sformatf("Timeout in %s: offset %h never read %h in %0d reads",
                                name, ofs, exp, limit));
         end
      end
   endtask

   task automatic pulse_source(input irq_vec_t pulse);
      begin
         @(posedge clock_in);
         irq_src <= pulse;
         @(posedge clock_in);
         irq_src <= '0;
      end
   endtask

   task automatic wait_irq(input string name, input irq_vec_t exp, input int limit);
      int waited;
      begin
         waited = 0;
         @(negedge clock_in);
         while ((irq_lines !== exp) && (waited < limit)) begin
            @(negedge clock_in);
            waited = waited + 1;
         end
         if (irq_lines !== exp) begin
            abort_run($sformatf("Timeout in %s: irq_lines wait for %b expired after %0d cycles",
                                name, exp, limit));
         end
      end
   endtask

   task automatic run_case(input int op, input io_ofs_t ofs, input io_byte_t data,
                           input io_byte_t exp, input bit err, input string name);
      apb_rsp_t rsp;
      apb_rsp_t rsp_exp;
      irq_vec_t irq_exp;
      begin
         rsp_exp.prdata  = exp;
         rsp_exp.pready  = 1'b1;
         rsp_exp.pslverr = err;
         irq_exp         = exp[4:0];
         case (op)
            1: begin
               apb_transfer(1'b1, ofs, data, rsp);
               check_rsp(name, rsp_exp, rsp);
            end
            2: begin
               apb_transfer(1'b0, ofs, 8'h00, rsp);
               check_rsp(name, rsp_exp, rsp);
               check_byte(name, exp, rsp.prdata);
            end
            3: begin
               apb_transfer(1'b1, ofs, data, rsp);
               check_rsp(name, rsp_exp, rsp);
               apb_transfer(1'b0, ofs, 8'h00, rsp);
               check_rsp(name, rsp_exp, rsp);
               check_byte(name, exp, rsp.prdata);
            end
            4: pulse_source(data[4:0]);
            5: wait_irq(name, irq_exp, data);
            6: begin
               @(negedge clock_in);
               check_irq(name, irq_exp, irq_lines);
            end
            default: abort_run($sformatf("Unknown operation %0d in case %s", op, name));
         endcase
      end
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial begin : main_seq
      int       fd;
      int       n;
      int       op;
      int       err;
      io_ofs_t  ofs;
      io_byte_t data;
      io_byte_t exp;
      string    name;
      string    line;
      apb_rsp_t idle_rsp;
      case_count  = 0;
      synch_reset = 1'b1;
      apb_req     = '0;
      irq_src     = '0;
      repeat (5) @(posedge clock_in);
      synch_reset <= 1'b0;

      // Idle bus and quiet irq lines out of reset
      idle_rsp.prdata  = 8'h00;
      idle_rsp.pready  = 1'b1;
      idle_rsp.pslverr = 1'b0;
      @(negedge clock_in);
      check_rsp("reset_idle", idle_rsp, apb_rsp);
      check_irq("reset_irq", '0, irq_lines);

      // Let the divider run past its low byte so a missed DIV clear shows up
      poll_read("div_running", 8'h04, 8'h01, DIV_POLL_LIMIT);

      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
         abort_run($sformatf("Could not open case file %s", CASE_FILE));
      end else begin
         while ($fgets(line, fd) != 0) begin
            if ((line.len() > 0) && (line.getc(0) != "#")) begin
               n = $sscanf(line, "%d %h %h %h %d %s", op, ofs, data, exp, err, name);
               if (n == 6) begin
                  run_case(op, ofs, data, exp, err[0], name);
                  case_count = case_count + 1;
               end else if (n > 0) begin
                  abort_run($sformatf("Malformed line in case file: %s", line));
               end
            end
         end
         $fclose(fd);
         if (case_count == 0) begin
            abort_run("No cases were read from the case file");
         end else begin
            $display("NO ERRORS");
            $finish;
         end
      end
   end

endmodule

// File: io_regs.f
+incdir+include
hdl/io_regs_pkg.sv
hdl/io_bus_control.sv
hdl/timer_unit.sv
hdl/interrupt_unit.sv
hdl/misc_reg_bank.sv
hdl/io_regs_top.sv
verif/io_regs_tb.sv

// File: verif/io_regs_cases.txt
# op: 1 write, 2 read, 3 write then read back, 4 pulse irq_src, 5 wait irq_lines, 6 check irq_lines
# op offset data expected pslverr name  (op 5 takes its timeout in cycles from the data column)
2 01 00 00 0 reset_sb
2 02 00 7c 0 reset_sc
2 4d 00 fd 0 reset_key1
2 56 00 3e 0 reset_rp
2 07 00 f8 0 reset_tac
2 0f 00 e0 0 reset_if
3 01 ff ff 0 rw_sb_ff
3 01 00 00 0 rw_sb_00
3 02 ff ff 0 rw_sc_ff
3 02 00 7c 0 rw_sc_00
3 4d ff ff 0 rw_key1_ff
3 4d 00 fd 0 rw_key1_00
3 56 ff ff 0 rw_rp_ff
3 56 00 3e 0 rw_rp_00
3 06 ff ff 0 rw_tma_ff
3 06 00 00 0 rw_tma_00
3 ff ff 1f 0 rw_ie_ff
3 ff 00 00 0 rw_ie_00
3 07 ff ff 0 rw_tac_ff
3 07 00 f8 0 rw_tac_00
2 03 00 ff 1 unmapped_read
1 03 55 00 1 unmapped_write
2 01 00 00 0 unmapped_keeps_sb
2 02 00 7c 0 unmapped_keeps_sc
3 04 00 00 0 div_clear
3 06 a5 a5 0 timer_tma
1 05 fe 00 0 timer_tima
1 ff 04 00 0 timer_ie
1 07 05 00 0 timer_tac_on
5 00 64 04 0 timer_irq_wait
1 07 00 00 0 timer_tac_off
2 05 00 a5 0 timer_reload
2 0f 00 e4 0 timer_if_bit
1 0f 00 00 0 timer_if_clear
5 00 0a 00 0 timer_irq_cleared
4 00 01 00 0 pulse_vblank
2 0f 00 e1 0 if_vblank
6 00 00 00 0 masked_vblank
1 ff 01 00 0 ie_vblank
5 00 0a 01 0 irq_vblank_wait
4 00 02 00 0 pulse_lcdstat
4 00 04 00 0 pulse_timer_pin
4 00 08 00 0 pulse_serial
4 00 10 00 0 pulse_joypad
2 0f 00 fb 0 if_all_pins
6 00 00 01 0 masked_others
1 ff 1f 00 0 ie_all
5 00 0a 1b 0 irq_all_wait
1 0f 00 00 0 if_clear_all
5 00 0a 00 0 irq_clear_wait
